// File: verilog/pipe_pkg.sv
package pipe_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned RF_NUM_REGS = 32;
  localparam int unsigned RF_ADDR_W   = 5;
  localparam int unsigned XLEN        = 32;

  // Register index, data word and instruction word
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [XLEN-1:0]      rf_data_t;
  typedef logic [31:0]          instr_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  // funct3 values
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;
  localparam logic [2:0] FUNCT3_LW      = 3'b010;

  // funct7 values for R-type
  localparam logic [6:0] FUNCT7_ZERO = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // Operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE,
    SEL_FW_EX,
    SEL_FW_WB
  } op_fw_mux_e;

  //////////////////////////////
  // Pipeline structs
  //////////////////////////////

  typedef struct packed {
    logic   instr_valid;
    instr_t instr;
  } if_id_pipe_t;

  typedef struct packed {
    logic     instr_valid;
    logic     rf_we;
    rf_addr_t rf_waddr;
    logic     lsu_en;
    alu_op_e  alu_op;
    rf_data_t operand_a;
    rf_data_t operand_b;
    rf_data_t imm;
  } id_ex_pipe_t;

  // rf_wdata is the ALU result, or the load address for loads
  typedef struct packed {
    logic     instr_valid;
    logic     rf_we;
    rf_addr_t rf_waddr;
    logic     lsu_en;
    rf_data_t rf_wdata;
  } ex_wb_pipe_t;

  typedef struct packed {
    alu_op_e    alu_op;
    logic [1:0] rf_re;
    rf_addr_t   rf_raddr_a;
    rf_addr_t   rf_raddr_b;
    logic       rf_we;
    rf_addr_t   rf_waddr;
    logic       lsu_en;
    rf_data_t   imm;
    logic       use_imm;
    logic       illegal;
  } decode_t;

  typedef struct packed {
    logic       load_stall;
    logic       deassert_we;
    op_fw_mux_e operand_a_fw_mux_sel;
    op_fw_mux_e operand_b_fw_mux_sel;
  } ctrl_byp_t;

endpackage

// File: verilog/pipe_decoder.sv
`timescale 1ns/1ns

module pipe_decoder (
  input  pipe_pkg::instr_t  instr_i,
  output pipe_pkg::decode_t decode_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Register fields sit at fixed positions in every format
    decode_o            = '0;
    decode_o.alu_op     = pipe_pkg::ALU_ADD;
    decode_o.rf_raddr_a = instr_i[19:15];
    decode_o.rf_raddr_b = instr_i[24:20];
    decode_o.rf_waddr   = instr_i[11:7];
    // I-type immediate, sign extended
    decode_o.imm        = {{20{instr_i[31]}}, instr_i[31:20]};

    case (opcode)
      pipe_pkg::OPC_OP: begin
        decode_o.rf_re   = 2'b11;
        decode_o.rf_we   = 1'b1;
        // Only SUB may carry a nonzero funct7
        decode_o.illegal = (funct7 != pipe_pkg::FUNCT7_ZERO) &&
                           !((funct7 == pipe_pkg::FUNCT7_SUB) &&
                             (funct3 == pipe_pkg::FUNCT3_ADD_SUB));
        case (funct3)
          pipe_pkg::FUNCT3_ADD_SUB: begin
            decode_o.alu_op = (funct7 == pipe_pkg::FUNCT7_SUB) ? pipe_pkg::ALU_SUB
                                                                : pipe_pkg::ALU_ADD;
          end
          pipe_pkg::FUNCT3_XOR: decode_o.alu_op = pipe_pkg::ALU_XOR;
          pipe_pkg::FUNCT3_OR:  decode_o.alu_op = pipe_pkg::ALU_OR;
          pipe_pkg::FUNCT3_AND: decode_o.alu_op = pipe_pkg::ALU_AND;
          default:              decode_o.illegal = 1'b1;
        endcase
      end
      pipe_pkg::OPC_OP_IMM: begin
        // rs1 only, immediate replaces operand b
        decode_o.rf_re   = 2'b01;
        decode_o.rf_we   = 1'b1;
        decode_o.use_imm = 1'b1;
        case (funct3)
          pipe_pkg::FUNCT3_ADD_SUB: decode_o.alu_op = pipe_pkg::ALU_ADD;
          pipe_pkg::FUNCT3_XOR:     decode_o.alu_op = pipe_pkg::ALU_XOR;
          pipe_pkg::FUNCT3_OR:      decode_o.alu_op = pipe_pkg::ALU_OR;
          pipe_pkg::FUNCT3_AND:     decode_o.alu_op = pipe_pkg::ALU_AND;
          default:                  decode_o.illegal = 1'b1;
        endcase
      end
      pipe_pkg::OPC_LOAD: begin
        // Word loads only
        decode_o.rf_re   = 2'b01;
        decode_o.rf_we   = 1'b1;
        decode_o.lsu_en  = 1'b1;
        decode_o.use_imm = 1'b1;
        decode_o.illegal = (funct3 != pipe_pkg::FUNCT3_LW);
      end
      default: decode_o.illegal = 1'b1;
    endcase

    // Illegal words travel on as a nop
    if (decode_o.illegal) begin
      decode_o.rf_re   = 2'b00;
      decode_o.rf_we   = 1'b0;
      decode_o.lsu_en  = 1'b0;
      decode_o.use_imm = 1'b0;
    end

    // x0 is never written
    if (decode_o.rf_waddr == '0) begin
      decode_o.rf_we = 1'b0;
    end
  end

endmodule

// File: verilog/pipe_regfile.sv
`timescale 1ns/1ns

module pipe_regfile (
  input  logic               clk,
  input  logic               reset_i,
  input  pipe_pkg::rf_addr_t raddr_a_i,
  input  pipe_pkg::rf_addr_t raddr_b_i,
  output pipe_pkg::rf_data_t rdata_a_o,
  output pipe_pkg::rf_data_t rdata_b_o,
  input  logic               we_i,
  input  pipe_pkg::rf_addr_t waddr_i,
  input  pipe_pkg::rf_data_t wdata_i
);

  pipe_pkg::rf_data_t regs [pipe_pkg::RF_NUM_REGS];

  // Single write port, x0 entry never updated
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < pipe_pkg::RF_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Reads return the old value during a write, WB forward covers it
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: verilog/pipe_hazard_ctrl.sv
`timescale 1ns/1ns

module pipe_hazard_ctrl (
  input  pipe_pkg::decode_t     decode_id_i,
  input  pipe_pkg::if_id_pipe_t if_id_pipe_i,
  input  pipe_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  pipe_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  logic                  wb_ready_i,
  output pipe_pkg::ctrl_byp_t   ctrl_byp_o
);

  pipe_pkg::rf_addr_t rf_raddr_id [2];
  logic [1:0]         rf_re_id;
  // ID read vs EX or WB write, qualified and x0 excluded
  logic [1:0]         rf_rd_ex_match;
  logic [1:0]         rf_rd_wb_match;
  logic               rf_we_ex;
  logic               rf_we_wb;
  logic               lsu_en_ex;

  // Qualified write enables of the younger stages
  assign rf_we_ex  = id_ex_pipe_i.instr_valid && id_ex_pipe_i.rf_we;
  assign rf_we_wb  = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.rf_we;
  assign lsu_en_ex = id_ex_pipe_i.instr_valid && id_ex_pipe_i.lsu_en;

  // Port 0 is rs1, port 1 is rs2
  assign rf_raddr_id[0] = decode_id_i.rf_raddr_a;
  assign rf_raddr_id[1] = decode_id_i.rf_raddr_b;
  assign rf_re_id       = decode_id_i.rf_re & {2{if_id_pipe_i.instr_valid}};

  for (genvar i = 0; i < 2; i++) begin : gen_match
    assign rf_rd_ex_match[i] = rf_we_ex && rf_re_id[i] && (|rf_raddr_id[i]) &&
                               (id_ex_pipe_i.rf_waddr == rf_raddr_id[i]);
    assign rf_rd_wb_match[i] = rf_we_wb && rf_re_id[i] && (|rf_raddr_id[i]) &&
                               (ex_wb_pipe_i.rf_waddr == rf_raddr_id[i]);
  end

  //////////////////////////////
  // Stall and forward control
  //////////////////////////////

  always_comb begin
    // Load data is not there yet while the load sits in EX,
    // or while WB still waits for the response
    ctrl_byp_o.load_stall = (lsu_en_ex && (|rf_rd_ex_match)) ||
                            (!wb_ready_i && (|rf_rd_wb_match));

    // Illegal word in ID retires without a write
    ctrl_byp_o.deassert_we = if_id_pipe_i.instr_valid && decode_id_i.illegal;

    ctrl_byp_o.operand_a_fw_mux_sel = pipe_pkg::SEL_REGFILE;
    ctrl_byp_o.operand_b_fw_mux_sel = pipe_pkg::SEL_REGFILE;

    // WB first, EX overrides since it holds the newer value
    if (rf_rd_wb_match[0]) begin
      ctrl_byp_o.operand_a_fw_mux_sel = pipe_pkg::SEL_FW_WB;
    end
    if (rf_rd_wb_match[1]) begin
      ctrl_byp_o.operand_b_fw_mux_sel = pipe_pkg::SEL_FW_WB;
    end
    if (rf_rd_ex_match[0]) begin
      ctrl_byp_o.operand_a_fw_mux_sel = pipe_pkg::SEL_FW_EX;
    end
    if (rf_rd_ex_match[1]) begin
      ctrl_byp_o.operand_b_fw_mux_sel = pipe_pkg::SEL_FW_EX;
    end
  end

  // A stall always belongs to a real instruction in ID
  always_comb begin
    if (ctrl_byp_o.load_stall) begin
      assert (if_id_pipe_i.instr_valid)
        else $error("load_stall without valid instruction in ID");
    end
  end

  // x0 operands always come from the register file
  always_comb begin
    if (decode_id_i.rf_raddr_a == '0) begin
      assert (ctrl_byp_o.operand_a_fw_mux_sel == pipe_pkg::SEL_REGFILE)
        else $error("operand a forwarded for x0");
    end
    if (decode_id_i.rf_raddr_b == '0) begin
      assert (ctrl_byp_o.operand_b_fw_mux_sel == pipe_pkg::SEL_REGFILE)
        else $error("operand b forwarded for x0");
    end
  end

endmodule

// File: verilog/pipe_id_stage.sv
`timescale 1ns/1ns

module pipe_id_stage (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  halt_i,
  input  logic                  instr_valid_i,
  input  pipe_pkg::instr_t      instr_i,
  output logic                  instr_ready_o,
  input  pipe_pkg::ctrl_byp_t   ctrl_byp_i,
  output pipe_pkg::decode_t     decode_o,
  output pipe_pkg::if_id_pipe_t if_id_pipe_o,
  output pipe_pkg::rf_addr_t    rf_raddr_a_o,
  output pipe_pkg::rf_addr_t    rf_raddr_b_o,
  input  pipe_pkg::rf_data_t    rf_rdata_a_i,
  input  pipe_pkg::rf_data_t    rf_rdata_b_i,
  input  pipe_pkg::rf_data_t    fw_ex_data_i,
  input  pipe_pkg::rf_data_t    fw_wb_data_i,
  output pipe_pkg::id_ex_pipe_t id_ex_pipe_o
);

  pipe_pkg::if_id_pipe_t if_id_q;
  pipe_pkg::id_ex_pipe_t id_ex_q;
  pipe_pkg::decode_t     decode;
  pipe_pkg::rf_data_t    operand_a;
  pipe_pkg::rf_data_t    operand_b_fw;
  pipe_pkg::rf_data_t    operand_b;
  logic                  id_hold;

  // Three way operand source select
  function automatic pipe_pkg::rf_data_t fw_mux(
    input pipe_pkg::op_fw_mux_e sel,
    input pipe_pkg::rf_data_t   rf_data,
    input pipe_pkg::rf_data_t   ex_data,
    input pipe_pkg::rf_data_t   wb_data
  );
    case (sel)
      pipe_pkg::SEL_FW_EX: return ex_data;
      pipe_pkg::SEL_FW_WB: return wb_data;
      default:             return rf_data;
    endcase
  endfunction

  // IF/ID frozen by halt and by load-use stall
  assign id_hold       = halt_i || ctrl_byp_i.load_stall;
  // Nothing is taken while in reset
  assign instr_ready_o = !id_hold && !reset_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      if_id_q.instr_valid <= 1'b0;
    end else if (!id_hold) begin
      if_id_q.instr_valid <= instr_valid_i;
      if_id_q.instr       <= instr_i;
    end
  end

  pipe_decoder decoder_i (
    .instr_i  (if_id_q.instr),
    .decode_o (decode)
  );

  assign rf_raddr_a_o = decode.rf_raddr_a;
  assign rf_raddr_b_o = decode.rf_raddr_b;

  // Forward muxes, immediate takes operand b for I-type and loads
  assign operand_a    = fw_mux(ctrl_byp_i.operand_a_fw_mux_sel, rf_rdata_a_i,
                               fw_ex_data_i, fw_wb_data_i);
  assign operand_b_fw = fw_mux(ctrl_byp_i.operand_b_fw_mux_sel, rf_rdata_b_i,
                               fw_ex_data_i, fw_wb_data_i);
  assign operand_b    = decode.use_imm ? decode.imm : operand_b_fw;

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_q.instr_valid <= 1'b0;
      id_ex_q.rf_we       <= 1'b0;
      id_ex_q.lsu_en      <= 1'b0;
    end else if (!halt_i) begin
      // Load-use stall drops a bubble into EX
      id_ex_q.instr_valid <= if_id_q.instr_valid && !ctrl_byp_i.load_stall;
      id_ex_q.rf_we       <= decode.rf_we && !ctrl_byp_i.deassert_we;
      id_ex_q.lsu_en      <= decode.lsu_en;
      id_ex_q.rf_waddr    <= decode.rf_waddr;
      id_ex_q.alu_op      <= decode.alu_op;
      id_ex_q.operand_a   <= operand_a;
      id_ex_q.operand_b   <= operand_b;
      id_ex_q.imm         <= decode.imm;
    end
  end

  assign decode_o     = decode;
  assign if_id_pipe_o = if_id_q;
  assign id_ex_pipe_o = id_ex_q;

  // No word is taken while WB holds the pipeline
  assert property (@(posedge clk) disable iff (reset_i) halt_i |-> !instr_ready_o)
    else $error("instr_ready_o high during halt");

endmodule

// File: verilog/pipe_ex_stage.sv
`timescale 1ns/1ns

module pipe_ex_stage (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  halt_i,
  input  pipe_pkg::id_ex_pipe_t id_ex_pipe_i,
  output pipe_pkg::rf_data_t    alu_result_o,
  output pipe_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  pipe_pkg::ex_wb_pipe_t ex_wb_q;
  pipe_pkg::rf_data_t    alu_out;
  pipe_pkg::rf_data_t    lsu_addr;

  always_comb begin
    case (id_ex_pipe_i.alu_op)
      pipe_pkg::ALU_SUB: alu_out = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      pipe_pkg::ALU_AND: alu_out = id_ex_pipe_i.operand_a & id_ex_pipe_i.operand_b;
      pipe_pkg::ALU_OR:  alu_out = id_ex_pipe_i.operand_a | id_ex_pipe_i.operand_b;
      pipe_pkg::ALU_XOR: alu_out = id_ex_pipe_i.operand_a ^ id_ex_pipe_i.operand_b;
      default:           alu_out = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
    endcase
  end

  // Load address is rs1 plus offset
  assign lsu_addr     = id_ex_pipe_i.operand_a + id_ex_pipe_i.imm;
  // Also the EX forward value
  assign alu_result_o = id_ex_pipe_i.lsu_en ? lsu_addr : alu_out;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_wb_q.instr_valid <= 1'b0;
      ex_wb_q.rf_we       <= 1'b0;
      ex_wb_q.lsu_en      <= 1'b0;
    end else if (!halt_i) begin
      ex_wb_q.instr_valid <= id_ex_pipe_i.instr_valid;
      ex_wb_q.rf_we       <= id_ex_pipe_i.rf_we;
      ex_wb_q.lsu_en      <= id_ex_pipe_i.lsu_en;
      ex_wb_q.rf_waddr    <= id_ex_pipe_i.rf_waddr;
      ex_wb_q.rf_wdata    <= alu_result_o;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

// File: verilog/pipe_wb_stage.sv
`timescale 1ns/1ns

module pipe_wb_stage (
  input  logic                  clk,
  input  pipe_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  logic                  data_rvalid_i,
  input  pipe_pkg::rf_data_t    data_rdata_i,
  output logic                  data_req_o,
  output pipe_pkg::rf_data_t    data_addr_o,
  output logic                  wb_ready_o,
  output logic                  rf_we_o,
  output pipe_pkg::rf_addr_t    rf_waddr_o,
  output pipe_pkg::rf_data_t    rf_wdata_o
);

  logic load_wb;

  assign load_wb = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en;

  // Request level stays up until the response strobe,
  // EX/WB is frozen meanwhile so the address holds
  assign data_req_o  = load_wb;
  assign data_addr_o = ex_wb_pipe_i.rf_wdata;

  // Waiting load blocks the whole pipe
  assign wb_ready_o = !(load_wb && !data_rvalid_i);

  // Write strobe, load data replaces the address for loads
  assign rf_we_o    = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.rf_we && wb_ready_o;
  assign rf_waddr_o = ex_wb_pipe_i.rf_waddr;
  assign rf_wdata_o = ex_wb_pipe_i.lsu_en ? data_rdata_i : ex_wb_pipe_i.rf_wdata;

  // Address must not move under an open request
  assert property (@(posedge clk) (data_req_o && !data_rvalid_i) |=> $stable(data_addr_o))
    else $error("data_addr_o changed during pending request");

endmodule

// File: verilog/pipe_top.sv
`timescale 1ns/1ns

module pipe_top (
  input  logic               clk,
  input  logic               reset_i,
  // Fetch port
  input  logic               instr_valid_i,
  input  pipe_pkg::instr_t   instr_i,
  output logic               instr_ready_o,
  // Data port
  output logic               data_req_o,
  output pipe_pkg::rf_data_t data_addr_o,
  input  logic               data_rvalid_i,
  input  pipe_pkg::rf_data_t data_rdata_i,
  // Writeback trace
  output logic               rf_we_o,
  output pipe_pkg::rf_addr_t rf_waddr_o,
  output pipe_pkg::rf_data_t rf_wdata_o
);

  pipe_pkg::decode_t     decode_id;
  pipe_pkg::if_id_pipe_t if_id_pipe;
  pipe_pkg::id_ex_pipe_t id_ex_pipe;
  pipe_pkg::ex_wb_pipe_t ex_wb_pipe;
  pipe_pkg::ctrl_byp_t   ctrl_byp;
  pipe_pkg::rf_addr_t    rf_raddr_a;
  pipe_pkg::rf_addr_t    rf_raddr_b;
  pipe_pkg::rf_data_t    rf_rdata_a;
  pipe_pkg::rf_data_t    rf_rdata_b;
  pipe_pkg::rf_data_t    alu_result_ex;
  logic                  wb_ready;
  logic                  halt;

  // WB wait freezes every stage
  assign halt = !wb_ready;

  pipe_id_stage id_stage_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .halt_i        (halt),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .ctrl_byp_i    (ctrl_byp),
    .decode_o      (decode_id),
    .if_id_pipe_o  (if_id_pipe),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .fw_ex_data_i  (alu_result_ex),
    .fw_wb_data_i  (rf_wdata_o),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  pipe_hazard_ctrl hazard_ctrl_i (
    .decode_id_i  (decode_id),
    .if_id_pipe_i (if_id_pipe),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_wb_pipe_i (ex_wb_pipe),
    .wb_ready_i   (wb_ready),
    .ctrl_byp_o   (ctrl_byp)
  );

  // Write port shared with the trace outputs
  pipe_regfile regfile_i (
    .clk       (clk),
    .reset_i   (reset_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we_o),
    .waddr_i   (rf_waddr_o),
    .wdata_i   (rf_wdata_o)
  );

  pipe_ex_stage ex_stage_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .halt_i       (halt),
    .id_ex_pipe_i (id_ex_pipe),
    .alu_result_o (alu_result_ex),
    .ex_wb_pipe_o (ex_wb_pipe)
  );

  pipe_wb_stage wb_stage_i (
    .clk           (clk),
    .ex_wb_pipe_i  (ex_wb_pipe),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .wb_ready_o    (wb_ready),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o)
  );

endmodule

// File: include/pipe_tb_table.svh
// Columns: test, instruction word, valid, writes, rd, expected value
// Expected values come from in-order execution starting with all registers at zero
localparam int NUM_ENTRIES = 29;

localparam entry_t STIM_TABLE [NUM_ENTRIES] = '{
  // Independent I-type and R-type
  '{8'd1, 32'h00500093, 1'b1, 1'b1, 5'd1,  32'h00000005},
  '{8'd1, 32'hFFD00113, 1'b1, 1'b1, 5'd2,  32'hFFFFFFFD},
  '{8'd1, 32'h0F006193, 1'b1, 1'b1, 5'd3,  32'h000000F0},
  '{8'd1, 32'h55504213, 1'b1, 1'b1, 5'd4,  32'h00000555},
  '{8'd1, 32'h7FF07293, 1'b1, 1'b1, 5'd5,  32'h00000000},
  '{8'd1, 32'h00000000, 1'b0, 1'b0, 5'd0,  32'h00000000},
  '{8'd1, 32'h00418333, 1'b1, 1'b1, 5'd6,  32'h00000645},
  // Back to back, EX forward
  '{8'd2, 32'h401303B3, 1'b1, 1'b1, 5'd7,  32'h00000640},
  '{8'd2, 32'h00717433, 1'b1, 1'b1, 5'd8,  32'h00000640},
  '{8'd2, 32'h007474B3, 1'b1, 1'b1, 5'd9,  32'h00000640},
  // One apart, WB forward, then newer value wins
  '{8'd3, 32'h00148513, 1'b1, 1'b1, 5'd10, 32'h00000641},
  '{8'd3, 32'h00700593, 1'b1, 1'b1, 5'd11, 32'h00000007},
  '{8'd3, 32'h00B50633, 1'b1, 1'b1, 5'd12, 32'h00000648},
  '{8'd3, 32'h00100693, 1'b1, 1'b1, 5'd13, 32'h00000001},
  '{8'd3, 32'h00200693, 1'b1, 1'b1, 5'd13, 32'h00000002},
  '{8'd3, 32'h00D68733, 1'b1, 1'b1, 5'd14, 32'h00000004},
  // Loads with an immediate use
  '{8'd4, 32'h04000793, 1'b1, 1'b1, 5'd15, 32'h00000040},
  '{8'd4, 32'h0087A803, 1'b1, 1'b1, 5'd16, 32'h00000123},
  '{8'd4, 32'h00F808B3, 1'b1, 1'b1, 5'd17, 32'h00000163},
  '{8'd4, 32'hFFC7A903, 1'b1, 1'b1, 5'd18, 32'h000000F3},
  '{8'd4, 32'h012049B3, 1'b1, 1'b1, 5'd19, 32'h000000F3},
  // Illegal words
  '{8'd5, 32'hFFFFFFFF, 1'b1, 1'b0, 5'd0,  32'h00000000},
  '{8'd5, 32'h00000000, 1'b1, 1'b0, 5'd0,  32'h00000000},
  '{8'd5, 32'h02B50AB3, 1'b1, 1'b0, 5'd0,  32'h00000000},
  '{8'd5, 32'h000A8B13, 1'b1, 1'b1, 5'd22, 32'h00000000},
  // x0 as target and source
  '{8'd6, 32'h00900013, 1'b1, 1'b0, 5'd0,  32'h00000000},
  '{8'd6, 32'h00000BB3, 1'b1, 1'b1, 5'd23, 32'h00000000},
  '{8'd6, 32'h00208033, 1'b1, 1'b0, 5'd0,  32'h00000000},
  '{8'd6, 32'h00300C13, 1'b1, 1'b1, 5'd24, 32'h00000003}
};

// File: sim/tb_pipe_top.sv
`timescale 1ns/1ns

module tb_pipe_top;

  typedef struct packed {
    logic [7:0]  test;
    logic [31:0] instr;
    logic        valid;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] val;
  } entry_t;

  `include "pipe_tb_table.svh"

  localparam int NUM_TESTS = 6;

  // Expected writeback, with a flag for the last one of its test
  typedef struct packed {
    logic [7:0]  test;
    logic [4:0]  rd;
    logic [31:0] val;
    logic        last;
  } exp_t;

  // Expected load address
  typedef struct packed {
    logic [7:0]  test;
    logic [31:0] addr;
  } addr_exp_t;

  logic               clk;
  logic               reset_i;
  logic               instr_valid_i;
  pipe_pkg::instr_t   instr_i;
  logic               instr_ready_o;
  logic               data_req_o;
  pipe_pkg::rf_data_t data_addr_o;
  logic               data_rvalid_i;
  pipe_pkg::rf_data_t data_rdata_i;
  logic               rf_we_o;
  pipe_pkg::rf_addr_t rf_waddr_o;
  pipe_pkg::rf_data_t rf_wdata_o;

  pipe_pkg::rf_data_t mem [256];
  pipe_pkg::rf_data_t arch_regs [32];
  exp_t               exp_q [$];
  addr_exp_t          addr_q [$];
  int                 errors;
  int                 checks;
  int                 tests_failed;
  int                 test_err [NUM_TESTS+1];
  integer             seed;
  int                 delay_cnt;
  logic               mem_busy;
  logic               req_open;
  logic               accepted;

  pipe_top pipe_top_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o)
  );

  always #5 clk = !clk;

  task automatic check_value(input int test, input string name,
                             input logic [31:0] exp_val, input logic [31:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_val, act_val);
      errors++;
      test_err[test]++;
    end
  endtask

  //////////////////////////////
  // Data memory with random delay
  //////////////////////////////

  always @(posedge clk) begin
    if (reset_i) begin
      data_rvalid_i <= 1'b0;
      mem_busy = 1'b0;
    end else if (data_rvalid_i) begin
      // Strobe closes the request at this edge
      data_rvalid_i <= 1'b0;
    end else if (data_req_o) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        delay_cnt = {$random(seed)} % 4;
      end
      if (delay_cnt == 0) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= mem[data_addr_o[9:2]];
        mem_busy = 1'b0;
      end else begin
        delay_cnt--;
      end
    end
  end

  // Writeback monitor, sampled mid cycle
  always @(negedge clk) begin
    exp_t e;
    if (!reset_i && rf_we_o) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected write to x%0d at %0t", rf_waddr_o, $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_value(e.test, "rf_waddr_o", {27'd0, e.rd}, {27'd0, rf_waddr_o});
        check_value(e.test, "rf_wdata_o", e.val, rf_wdata_o);
        if (e.last) begin
          if (test_err[e.test] != 0) begin
            tests_failed++;
          end
          $display("test %0d done, %0d errors", e.test, test_err[e.test]);
        end
      end
    end
  end

  // Each new load request must carry base plus offset
  always @(negedge clk) begin
    addr_exp_t a;
    if (reset_i) begin
      req_open = 1'b0;
    end else begin
      if (data_req_o && !req_open) begin
        req_open = 1'b1;
        if (addr_q.size() == 0) begin
          $display("Unexpected data request to %h at %0t", data_addr_o, $time);
          errors++;
        end else begin
          a = addr_q.pop_front();
          check_value(a.test, "data_addr_o", a.addr, data_addr_o);
        end
      end
      // Response strobe ends the open request
      if (data_rvalid_i) begin
        req_open = 1'b0;
      end
    end
  end

  // Watchdog sized by the table length
  initial begin
    #(NUM_ENTRIES * 20 * 10);
    $display("Timeout, writebacks still missing after %0d cycles", NUM_ENTRIES * 20);
    $display("Verification failed");
    $finish;
  end

  initial begin
    exp_t      e;
    addr_exp_t a;
    bit        later;
    clk           = 1'b0;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    errors        = 0;
    checks        = 0;
    tests_failed  = 0;
    seed          = 84;
    delay_cnt     = 0;
    mem_busy      = 1'b0;
    req_open      = 1'b0;
    foreach (test_err[t]) begin
      test_err[t] = 0;
    end
    foreach (arch_regs[r]) begin
      arch_regs[r] = '0;
    end
    for (int k = 0; k < 256; k++) begin
      mem[k] = k * 16 + 3;
    end

    // Expected queues, last write per test marked
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      // Load address from the register state before this entry
      if (STIM_TABLE[i].valid && (STIM_TABLE[i].instr[6:0] == pipe_pkg::OPC_LOAD) &&
          (STIM_TABLE[i].instr[14:12] == pipe_pkg::FUNCT3_LW)) begin
        a.test = STIM_TABLE[i].test;
        a.addr = arch_regs[STIM_TABLE[i].instr[19:15]] +
                 {{20{STIM_TABLE[i].instr[31]}}, STIM_TABLE[i].instr[31:20]};
        addr_q.push_back(a);
      end
      if (STIM_TABLE[i].we) begin
        arch_regs[STIM_TABLE[i].rd] = STIM_TABLE[i].val;
        later = 1'b0;
        for (int j = i + 1; j < NUM_ENTRIES; j++) begin
          if (STIM_TABLE[j].we && STIM_TABLE[j].test == STIM_TABLE[i].test) begin
            later = 1'b1;
          end
        end
        e.test = STIM_TABLE[i].test;
        e.rd   = STIM_TABLE[i].rd;
        e.val  = STIM_TABLE[i].val;
        e.last = !later;
        exp_q.push_back(e);
      end
    end

    repeat (4) @(posedge clk);
    reset_i <= 1'b0;

    // Hold each word until an edge with ready high takes it
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      @(posedge clk);
      instr_valid_i <= STIM_TABLE[i].valid;
      instr_i       <= STIM_TABLE[i].instr;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = instr_ready_o;
        if (!accepted) begin
          @(posedge clk);
        end
      end
    end
    @(posedge clk);
    instr_valid_i <= 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // Room for stray writes after the last one
    repeat (8) @(posedge clk);

    if (addr_q.size() != 0) begin
      $display("%0d load requests were never issued", addr_q.size());
      errors++;
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             NUM_TESTS, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
verilog/pipe_pkg.sv
verilog/pipe_decoder.sv
verilog/pipe_regfile.sv
verilog/pipe_hazard_ctrl.sv
verilog/pipe_id_stage.sv
verilog/pipe_ex_stage.sv
verilog/pipe_wb_stage.sv
verilog/pipe_top.sv
sim/tb_pipe_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= tb.f

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) include/pipe_tb_table.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
